// File: mini_fabric.f
rtl/fabric_pkg.sv
rtl/connect_block.sv
rtl/logic_op_unit.sv
rtl/compute_block.sv
rtl/fabric_column.sv
rtl/fabric_top.sv
sim/fabric_checker.sv
sim/fabric_tb.sv

// File: rtl/compute_block.sv
// Addressed compute block
module compute_block #(
   parameter fabric_pkg::cfg_addr_t block_addr = '0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  fabric_pkg::src_bus_t  src,
   input  logic                  cfg_en,
   input  fabric_pkg::cfg_addr_t cfg_addr,
   input  fabric_pkg::cfg_word_t cfg_data,
   output logic                  out
);

   import fabric_pkg::*;

   ////////////////////////////////////////////////////////////
   // Configuration decode
   ////////////////////////////////////////////////////////////

   logic cfg_hit;
   sel_t left_sel;
   sel_t right_sel;
   op_t  op_code;

   // A write lands here only when the strobe is up and the address is ours.
   // Addresses beyond the last block never match, so they are dropped.
   assign cfg_hit = cfg_en && (cfg_addr == block_addr);

   // Split the word into its three fields.
   assign left_sel  = cfg_data[cfg_left_lsb +: sel_width];
   assign right_sel = cfg_data[cfg_right_lsb +: sel_width];
   assign op_code   = cfg_data[cfg_op_lsb +: op_width];

   ////////////////////////////////////////////////////////////
   // Datapath
   ////////////////////////////////////////////////////////////

   logic left_bit;
   logic right_bit;

   connect_block left (
      .clk      (clk),
      .reset    (reset),
      .src      (src),
      .sel_data (left_sel),
      .sel_wr   (cfg_hit),
      .out      (left_bit)
   );

   connect_block right (
      .clk      (clk),
      .reset    (reset),
      .src      (src),
      .sel_data (right_sel),
      .sel_wr   (cfg_hit),
      .out      (right_bit)
   );

   // The chosen pair of bits is combined here.
   logic_op_unit op_unit (
      .clk     (clk),
      .reset   (reset),
      .a       (left_bit),
      .b       (right_bit),
      .op_data (op_code),
      .op_wr   (cfg_hit),
      .out     (out)
   );

endmodule

// File: rtl/connect_block.sv
// Configurable source selector
module connect_block (
   input  logic                 clk,
   input  logic                 reset,
   input  fabric_pkg::src_bus_t src,
   input  fabric_pkg::sel_t     sel_data,
   input  logic                 sel_wr,
   output logic                 out
);

   import fabric_pkg::*;

   // Current source select, loaded by a configuration write.
   sel_t sel_q;

   always_ff @(posedge clk) begin
      if (reset) begin
         sel_q <= '0;
      end else if (sel_wr) begin
         sel_q <= sel_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // 8-to-1 selection
   ////////////////////////////////////////////////////////////

   // Every select value has its own arm, so the output is never left
   // undriven.
   always_comb begin
      case (sel_q)
         3'd0: out = src[0];
         3'd1: out = src[1];
         3'd2: out = src[2];
         3'd3: out = src[3];
         3'd4: out = src[4];
         3'd5: out = src[5];
         3'd6: out = src[6];
         3'd7: out = src[7];
         default: out = 1'b0;
      endcase
   end

endmodule

// File: rtl/fabric_column.sv
// Column of compute blocks
module fabric_column #(
   parameter int col_index = 0
) (
   input  logic                  clk,
   input  logic                  reset,
   input  fabric_pkg::src_bus_t  src,
   input  logic                  cfg_en,
   input  fabric_pkg::cfg_addr_t cfg_addr,
   input  fabric_pkg::cfg_word_t cfg_data,
   output fabric_pkg::src_bus_t  outs
);

   import fabric_pkg::*;

   ////////////////////////////////////////////////////////////
   // Block array
   ////////////////////////////////////////////////////////////

   // All rows see the same source bus. Row r drives bit r of the
   // column output and answers to address col_index * num_rows + r.
   genvar r;
   generate
      for (r = 0; r < num_rows; r++) begin : row_gen
         localparam cfg_addr_t row_addr = cfg_addr_t'(col_index * num_rows + r);

         compute_block #(
            .block_addr (row_addr)
         ) block (
            .clk      (clk),
            .reset    (reset),
            .src      (src),
            .cfg_en   (cfg_en),
            .cfg_addr (cfg_addr),
            .cfg_data (cfg_data),
            .out      (outs[r])
         );
      end
   endgenerate

endmodule

// File: rtl/fabric_pkg.sv
// Fabric shared definitions
package fabric_pkg;

   ////////////////////////////////////////////////////////////
   // Fabric dimensions
   ////////////////////////////////////////////////////////////

   // Compute blocks per column, which is also the source bus width.
   localparam int num_rows = 8;
   localparam int num_cols = 2;

   localparam int sel_width  = 3;
   localparam int op_width   = 2;
   localparam int addr_width = 6;
   localparam int cfg_width  = 8;

   // Field positions inside a configuration word.
   localparam int cfg_left_lsb  = 5;
   localparam int cfg_right_lsb = 2;
   localparam int cfg_op_lsb    = 0;

   ////////////////////////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////////////////////////

   typedef logic [num_rows-1:0]   src_bus_t;
   typedef logic [cfg_width-1:0]  cfg_word_t;
   typedef logic [addr_width-1:0] cfg_addr_t;
   typedef logic [sel_width-1:0]  sel_t;
   typedef logic [op_width-1:0]   op_t;

   // Operation codes of a logic op unit.
   // Code 3 forces a zero so that every code has a defined result.
   localparam op_t op_and  = 2'd0;
   localparam op_t op_or   = 2'd1;
   localparam op_t op_xor  = 2'd2;
   localparam op_t op_zero = 2'd3;

endpackage

// File: rtl/fabric_top.sv
// Mini logic fabric top level
module fabric_top (
   input  logic                  clk,
   input  logic                  reset,
   input  fabric_pkg::src_bus_t  data_in,
   input  logic                  cfg_en,
   input  fabric_pkg::cfg_addr_t cfg_addr,
   input  fabric_pkg::cfg_word_t cfg_data,
   output fabric_pkg::src_bus_t  data_out
);

   import fabric_pkg::*;

   // Outputs of each column. Column 0 feeds column 1 directly.
   src_bus_t col_out [num_cols];

   ////////////////////////////////////////////////////////////
   // Columns
   ////////////////////////////////////////////////////////////

   fabric_column #(
      .col_index (0)
   ) col0 (
      .clk      (clk),
      .reset    (reset),
      .src      (data_in),
      .cfg_en   (cfg_en),
      .cfg_addr (cfg_addr),
      .cfg_data (cfg_data),
      .outs     (col_out[0])
   );

   fabric_column #(
      .col_index (num_cols - 1)
   ) col1 (
      .clk      (clk),
      .reset    (reset),
      .src      (col_out[0]),
      .cfg_en   (cfg_en),
      .cfg_addr (cfg_addr),
      .cfg_data (cfg_data),
      .outs     (col_out[num_cols-1])
   );

   ////////////////////////////////////////////////////////////
   // Output register
   ////////////////////////////////////////////////////////////

   // The only register on the data path. Everything in front of it is
   // combinational, so the fabric has a latency of one cycle.
   always_ff @(posedge clk) begin
      if (reset) begin
         data_out <= '0;
      end else begin
         data_out <= col_out[num_cols-1];
      end
   end

endmodule

// File: rtl/logic_op_unit.sv
// Two-input logic operation
module logic_op_unit (
   input  logic            clk,
   input  logic            reset,
   input  logic            a,
   input  logic            b,
   input  fabric_pkg::op_t op_data,
   input  logic            op_wr,
   output logic            out
);

   import fabric_pkg::*;

   logic and_out;
   logic or_out;
   logic xor_out;
   op_t  op_q;

   // All three functions are always formed; the register picks one.
   assign and_out = a & b;
   assign or_out  = a | b;
   assign xor_out = a ^ b;

   always_ff @(posedge clk) begin
      if (reset) begin
         op_q <= op_and;
      end else if (op_wr) begin
         op_q <= op_data;
      end
   end

   ////////////////////////////////////////////////////////////
   // Output select
   ////////////////////////////////////////////////////////////

   always_comb begin
      case (op_q)
         op_and:  out = and_out;
         op_or:   out = or_out;
         op_xor:  out = xor_out;
         op_zero: out = 1'b0;
         default: out = 1'b0;
      endcase
   end

endmodule

// File: run_sim.sh
#!/bin/sh
# Build and run the mini_fabric simulation with Verilator.
# The exit status is that of the simulation.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module fabric_tb \
   --Mdir obj_dir \
   -o fabric_sim \
   -f mini_fabric.f
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit $status
fi

./obj_dir/fabric_sim +verilator+error+limit+100
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation ended with status $status"
   exit $status
fi

echo "Simulation ended with status 0"
exit 0

// File: sim/fabric_checker.sv
// Fabric output assertions
module fabric_checker (
   input logic                 clk,
   input logic                 reset,
   input fabric_pkg::src_bus_t data_out
);

   import fabric_pkg::*;

   int reset_fails   = 0;
   int unknown_fails = 0;
   int zero_fails    = 0;
   int fail_count;

   assign fail_count = reset_fails + unknown_fails + zero_fails;

   ////////////////////////////////////////////////////////////
   // Column 1 operation registers
   ////////////////////////////////////////////////////////////

   logic [num_rows-1:0] col1_zero;

   genvar r;
   generate
      for (r = 0; r < num_rows; r++) begin : zero_gen
         assign col1_zero[r] = (col1.row_gen[r].block.op_unit.op_q == op_zero);
      end
   endgenerate

   ////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////

   // The output register clears on the edge that sees reset.
   assert property (@(posedge clk) $past(reset) |-> (data_out == '0))
      else begin
         reset_fails++;
         $error("data_out not zero after reset");
      end

   assert property (@(posedge clk) disable iff (reset) !$isunknown(data_out))
      else begin
         unknown_fails++;
         $error("data_out has unknown bits");
      end

   // If every block of the last column forces zero, so does the output.
   assert property (@(posedge clk) disable iff (reset) $past(&col1_zero) |-> (data_out == '0))
      else begin
         zero_fails++;
         $error("data_out not zero with column 1 forced to zero");
      end

endmodule

bind fabric_top fabric_checker checks (
   .clk      (clk),
   .reset    (reset),
   .data_out (data_out)
);

// File: sim/fabric_tb.sv
// Mini fabric testbench
module fabric_tb;

   import fabric_pkg::*;

   localparam int num_blocks = num_rows * num_cols;

   logic      clk;
   logic      reset;
   src_bus_t  data_in;
   logic      cfg_en;
   cfg_addr_t cfg_addr;
   cfg_word_t cfg_data;
   src_bus_t  data_out;

   // Copy of every block's configuration word, indexed by block address.
   cfg_word_t shadow [num_blocks];
   src_bus_t  exp_out;
   logic      exp_valid;
   src_bus_t  held_out;
   int        seed;

   fabric_top dut (
      .clk      (clk),
      .reset    (reset),
      .data_in  (data_in),
      .cfg_en   (cfg_en),
      .cfg_addr (cfg_addr),
      .cfg_data (cfg_data),
      .data_out (data_out)
   );

   always #10 clk = ~clk;

   ////////////////////////////////////////////////////////////
   // Reference model and comparison
   ////////////////////////////////////////////////////////////

   // Column 0 works on the input, column 1 on column 0's result.
   function automatic src_bus_t model_fabric(input src_bus_t in_bits);
      src_bus_t   col_bits;
      src_bus_t   result;
      cfg_word_t  word;
      logic [3:0] blk;
      sel_t       row;
      logic       lhs;
      logic       rhs;
      col_bits = in_bits;
      result   = '0;
      for (int c = 0; c < num_cols; c++) begin
         for (int r = 0; r < num_rows; r++) begin
            blk  = 4'(c * num_rows + r);
            row  = 3'(r);
            word = shadow[blk];
            lhs  = col_bits[word[7:5]];
            rhs  = col_bits[word[4:2]];
            case (op_t'(word[1:0]))
               op_and:  result[row] = lhs & rhs;
               op_or:   result[row] = lhs | rhs;
               op_xor:  result[row] = lhs ^ rhs;
               default: result[row] = 1'b0;
            endcase
         end
         col_bits = result;
      end
      return col_bits;
   endfunction

   task automatic check_value(input string name, input src_bus_t actual,
                              input src_bus_t expected);
      if (actual !== expected) begin
         $display("** Error: %s = 0x%0h, expected 0x%0h", name, actual, expected);
         $display("Testbench failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // The output register loads at each rising edge, so the expected value is
   // formed there from the configuration that held before the edge.
   always @(posedge clk) begin
      if (reset) begin
         shadow  = '{default: '0};
         exp_out = '0;
      end else begin
         exp_out = model_fabric(data_in);
         if (cfg_en && cfg_addr[5:4] == 2'b00) begin
            shadow[cfg_addr[3:0]] = cfg_data;
         end
      end
      exp_valid = 1'b1;
   end

   always @(negedge clk) begin
      if (exp_valid) begin
         check_value("data_out", data_out, exp_out);
      end
      if (dut.checks.fail_count != 0) begin
         $display("Testbench failed");
         $fatal(1, "An assertion in the output checker failed");
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus tasks
   ////////////////////////////////////////////////////////////

   task automatic apply_input(input src_bus_t value);
      @(negedge clk);
      cfg_en  = 1'b0;
      data_in = value;
   endtask

   task automatic write_cfg(input cfg_addr_t addr, input cfg_word_t word,
                            input src_bus_t value);
      @(negedge clk);
      cfg_en   = 1'b1;
      cfg_addr = addr;
      cfg_data = word;
      data_in  = value;
   endtask

   task automatic set_all(input cfg_word_t word);
      for (int b = 0; b < num_blocks; b++) begin
         write_cfg(cfg_addr_t'(b), word, src_bus_t'($random(seed)));
      end
   endtask

   task automatic run_random(input int cycles);
      for (int i = 0; i < cycles; i++) begin
         apply_input(src_bus_t'($random(seed)));
      end
   endtask

   task automatic wait_for_clear(output int waited);
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
         if (waited > 10) begin
            $display("Testbench failed");
            $fatal(1, "Timed out waiting for data_out to clear during reset");
         end
      end while (data_out !== '0);
   endtask

   task automatic apply_reset;
      int waited;
      cfg_en = 1'b0;
      reset  = 1'b1;
      wait_for_clear(waited);
      if (waited < 5) begin
         repeat (5 - waited) @(negedge clk);
      end
      reset = 1'b0;
   endtask

   // With every block at its reset value, each output bit is input bit 0.
   task automatic check_default(input int cycles);
      src_bus_t value;
      for (int i = 0; i < cycles; i++) begin
         value = src_bus_t'($random(seed));
         apply_input(value);
         @(negedge clk);
         check_value("data_out", data_out, {num_rows{value[0]}});
      end
   endtask

   initial begin
      seed      = 32'hb34f_5123;
      clk       = 1'b0;
      reset     = 1'b1;
      data_in   = '0;
      cfg_en    = 1'b0;
      cfg_addr  = '0;
      cfg_data  = '0;
      exp_valid = 1'b0;
      apply_reset();
      check_default(16);

      // Each operation in every block.
      for (int op = 0; op < 4; op++) begin
         set_all({3'd1, 3'd6, op_t'(op)});
         run_random(20);
      end

      // Walk every select value through both columns.
      for (int s = 0; s < num_rows; s++) begin
         for (int b = 0; b < num_blocks; b++) begin
            write_cfg(cfg_addr_t'(b),
                      {sel_t'(b + s), sel_t'(b + 2 * s + 1), (b < num_rows) ? op_or : op_xor},
                      src_bus_t'($random(seed)));
         end
         run_random(10);
      end

      // Writes beyond the last block must not disturb anything.
      apply_input(8'h5a);
      @(negedge clk);
      held_out = model_fabric(8'h5a);
      for (int a = num_blocks; a < 64; a += 3) begin
         write_cfg(cfg_addr_t'(a), cfg_word_t'($random(seed)), 8'h5a);
      end
      apply_input(8'h5a);
      @(negedge clk);
      check_value("data_out", data_out, held_out);

      for (int i = 0; i < 200; i++) begin
         if ($random(seed) & 1) begin
            write_cfg(cfg_addr_t'($random(seed) & 31), cfg_word_t'($random(seed)),
                      src_bus_t'($random(seed)));
         end else begin
            apply_input(src_bus_t'($random(seed)));
         end
      end

      apply_reset();
      check_default(16);
      apply_input('0);
      @(negedge clk);

      if (dut.checks.fail_count == 0) begin
         $display("Testbench passed");
         $finish;
      end else begin
         $display("Testbench failed");
         $fatal(1, "Assertion failures in the output checker");
      end
   end

endmodule
